// ==== rtl/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    localparam int DATA_W = 32;  // data and byte address width
    localparam int REG_AW = 5;   // 32 general registers
    localparam int RAM_AW = 8;   // word index into data_ram

    // addi plus the load/store subset
    typedef enum logic [3:0] {
        OP_ADDI,
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_LWL,
        OP_LWR,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_SWL,
        OP_SWR
    } mem_op_e;

    // mips exccode values for address errors
    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_ADEL = 5'd4,  // load or fetch
        EXC_ADES = 5'd5   // store
    } exc_code_e;

endpackage

`default_nettype wire

// ==== rtl/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram (
    input  wire                         clk,
    input  wire                         ram_en,
    input  wire  [3:0]                  ram_wen,
    input  wire  [lsu_pkg::RAM_AW-1:0]  ram_addr,
    input  wire  [lsu_pkg::DATA_W-1:0]  ram_wdata,
    output logic [lsu_pkg::DATA_W-1:0]  ram_rdata
);
    import lsu_pkg::*;

    logic [DATA_W-1:0] mem [2**RAM_AW];

    // contents start out cleared
    initial begin
        for (int i = 0; i < 2**RAM_AW; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (ram_en) begin
            ram_rdata <= mem[ram_addr];  // old word, read before write
            for (int b = 0; b < 4; b++) begin
                if (ram_wen[b]) begin
                    mem[ram_addr][8*b +: 8] <= ram_wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/load_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  wire lsu_pkg::mem_op_e       op,
    input  wire  [1:0]                  addr_low,
    input  wire  [lsu_pkg::DATA_W-1:0]  rdata,
    input  wire  [lsu_pkg::DATA_W-1:0]  rt_value,
    output logic [lsu_pkg::DATA_W-1:0]  load_data
);
    import lsu_pkg::*;

    logic [7:0]        byte_sel;
    logic [15:0]       half_sel;
    logic [DATA_W-1:0] lwl_data;
    logic [DATA_W-1:0] lwr_data;

    assign byte_sel = rdata[{addr_low, 3'b000} +: 8];
    assign half_sel = addr_low[1] ? rdata[31:16] : rdata[15:0];  // addr_low[0] is 0 here

    // lwl: memory bytes up to the address fill the top of rt
    assign lwl_data = (rdata << {~addr_low, 3'b000})
                    | (rt_value & (32'h00ff_ffff >> {addr_low, 3'b000}));

    // lwr: memory bytes from the address fill the bottom of rt
    assign lwr_data = (rdata >> {addr_low, 3'b000})
                    | (rt_value & ~(32'hffff_ffff >> {addr_low, 3'b000}));

    always_comb begin
        case (op)
            OP_LB:   load_data = {{24{byte_sel[7]}}, byte_sel};
            OP_LBU:  load_data = {24'd0, byte_sel};
            OP_LH:   load_data = {{16{half_sel[15]}}, half_sel};
            OP_LHU:  load_data = {16'd0, half_sel};
            OP_LWL:  load_data = lwl_data;
            OP_LWR:  load_data = lwr_data;
            default: load_data = rdata;  // lw
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/exe_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_stage (
    input  wire                           clk,
    input  wire                           reset,
    // issue port
    input  wire                           in_valid,
    output logic                          in_allowin,
    input  wire lsu_pkg::mem_op_e         in_op,
    input  wire  [lsu_pkg::REG_AW-1:0]    in_rs,
    input  wire  [lsu_pkg::REG_AW-1:0]    in_rt,
    input  wire  [lsu_pkg::REG_AW-1:0]    in_dest,
    input  wire  [15:0]                   in_imm,
    // register file read
    output logic [lsu_pkg::REG_AW-1:0]    rf_raddr1,
    output logic [lsu_pkg::REG_AW-1:0]    rf_raddr2,
    input  wire  [lsu_pkg::DATA_W-1:0]    rf_rdata1,
    input  wire  [lsu_pkg::DATA_W-1:0]    rf_rdata2,
    // bypass from mem
    input  wire                           ms_fwd_valid,
    input  wire  [lsu_pkg::REG_AW-1:0]    ms_fwd_dest,
    input  wire  [lsu_pkg::DATA_W-1:0]    ms_fwd_data,
    // to mem
    input  wire                           ms_allowin,
    output logic                          es_to_ms_valid,
    output lsu_pkg::mem_op_e              es_op,
    output logic [lsu_pkg::REG_AW-1:0]    es_dest,
    output logic                          es_gr_we,
    output logic [lsu_pkg::DATA_W-1:0]    es_result,
    output logic [lsu_pkg::DATA_W-1:0]    es_rt_value,
    output logic                          es_ex,
    output lsu_pkg::exc_code_e            es_exc_code,
    // data ram request
    output logic                          ram_en,
    output logic [3:0]                    ram_wen,
    output logic [lsu_pkg::RAM_AW-1:0]    ram_addr,
    output logic [lsu_pkg::DATA_W-1:0]    ram_wdata
);
    import lsu_pkg::*;

    logic              es_valid;
    logic [REG_AW-1:0] rs_r;
    logic [REG_AW-1:0] rt_r;
    logic [15:0]       imm_r;
    logic [DATA_W-1:0] rs_value;
    logic [1:0]        addr_low;
    logic              is_load;
    logic              is_store;

    assign in_allowin     = !es_valid || ms_allowin;  // never waits on its own
    assign es_to_ms_valid = es_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (in_allowin) begin
            es_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            es_op   <= in_op;
            rs_r    <= in_rs;
            rt_r    <= in_rt;
            es_dest <= in_dest;
            imm_r   <= in_imm;
        end
    end

    // operand read, the younger mem result wins over the register file
    assign rf_raddr1   = rs_r;
    assign rf_raddr2   = rt_r;
    assign rs_value    = (ms_fwd_valid && ms_fwd_dest == rs_r) ? ms_fwd_data : rf_rdata1;
    assign es_rt_value = (ms_fwd_valid && ms_fwd_dest == rt_r) ? ms_fwd_data : rf_rdata2;

    assign es_result = rs_value + {{(DATA_W-16){imm_r[15]}}, imm_r};  // address or addi sum
    assign addr_low  = es_result[1:0];

    assign is_load  = es_op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR};
    assign is_store = es_op inside {OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR};
    assign es_gr_we = (es_op == OP_ADDI || is_load) && es_dest != '0;

    // alignment check, partial-word ops never fault
    always_comb begin
        case (es_op)
            OP_LH, OP_LHU, OP_SH: es_ex = addr_low[0];
            OP_LW, OP_SW:         es_ex = addr_low != 2'b00;
            default:              es_ex = 1'b0;
        endcase
        if (!es_ex) begin
            es_exc_code = EXC_NONE;
        end else if (is_store) begin
            es_exc_code = EXC_ADES;
        end else begin
            es_exc_code = EXC_ADEL;
        end
    end

    assign ram_en   = es_valid && (is_load || is_store) && !es_ex && ms_allowin;
    assign ram_addr = es_result[RAM_AW+1:2];

    // byte lanes and store data placement
    always_comb begin
        ram_wen   = 4'b0000;  // loads write nothing
        ram_wdata = es_rt_value;
        case (es_op)
            OP_SB: begin
                ram_wen   = 4'b0001 << addr_low;
                ram_wdata = {4{es_rt_value[7:0]}};
            end
            OP_SH: begin
                ram_wen   = addr_low[1] ? 4'b1100 : 4'b0011;
                ram_wdata = {2{es_rt_value[15:0]}};
            end
            OP_SW: ram_wen = 4'b1111;
            OP_SWL: begin
                // top bytes of rt go to the address and below
                ram_wen   = {addr_low == 2'd3, addr_low[1], addr_low != 2'd0, 1'b1};
                ram_wdata = es_rt_value >> {~addr_low, 3'b000};
            end
            OP_SWR: begin
                ram_wen   = 4'b1111 << addr_low;
                ram_wdata = es_rt_value << {addr_low, 3'b000};
            end
            default: ram_wen = 4'b0000;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  wire                           clk,
    input  wire                           reset,
    // from exe
    input  wire                           es_to_ms_valid,
    output logic                          ms_allowin,
    input  wire lsu_pkg::mem_op_e         es_op,
    input  wire  [lsu_pkg::REG_AW-1:0]    es_dest,
    input  wire                           es_gr_we,
    input  wire  [lsu_pkg::DATA_W-1:0]    es_result,
    input  wire  [lsu_pkg::DATA_W-1:0]    es_rt_value,
    input  wire                           es_ex,
    input  wire lsu_pkg::exc_code_e       es_exc_code,
    input  wire  [lsu_pkg::DATA_W-1:0]    ram_rdata,
    // to wb
    input  wire                           ws_allowin,
    output logic                          ms_to_ws_valid,
    output lsu_pkg::mem_op_e              ms_op,
    output logic [lsu_pkg::REG_AW-1:0]    ms_dest,
    output logic                          ms_gr_we,
    output logic [lsu_pkg::DATA_W-1:0]    ms_result,
    output logic                          ms_ex,
    output lsu_pkg::exc_code_e            ms_exc_code,
    // bypass to exe
    output logic                          ms_fwd_valid,
    output logic [lsu_pkg::REG_AW-1:0]    ms_fwd_dest,
    output logic [lsu_pkg::DATA_W-1:0]    ms_fwd_data
);
    import lsu_pkg::*;

    logic              ms_valid;
    logic              gr_we_r;
    logic [DATA_W-1:0] exe_result_r;  // address or addi sum
    logic [DATA_W-1:0] rt_value_r;
    logic [DATA_W-1:0] load_data;
    logic              is_load;

    assign ms_allowin     = !ms_valid || ws_allowin;
    assign ms_to_ws_valid = ms_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin) begin
            ms_op        <= es_op;
            ms_dest      <= es_dest;
            gr_we_r      <= es_gr_we;
            exe_result_r <= es_result;
            rt_value_r   <= es_rt_value;
            ms_ex        <= es_ex;
            ms_exc_code  <= es_exc_code;
        end
    end

    load_align u_load_align (
        .op        (ms_op),
        .addr_low  (exe_result_r[1:0]),
        .rdata     (ram_rdata),
        .rt_value  (rt_value_r),
        .load_data (load_data)
    );

    assign is_load   = ms_op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR};
    // a faulting load keeps its address as the result
    assign ms_result = (is_load && !ms_ex) ? load_data : exe_result_r;
    assign ms_gr_we  = gr_we_r && !ms_ex;

    assign ms_fwd_valid = ms_valid && ms_gr_we;
    assign ms_fwd_dest  = ms_dest;
    assign ms_fwd_data  = ms_result;

endmodule

`default_nettype wire

// ==== rtl/wb_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
    input  wire                           clk,
    input  wire                           reset,
    // from mem
    input  wire                           ms_to_ws_valid,
    output logic                          ws_allowin,
    input  wire lsu_pkg::mem_op_e         ms_op,
    input  wire  [lsu_pkg::REG_AW-1:0]    ms_dest,
    input  wire                           ms_gr_we,
    input  wire  [lsu_pkg::DATA_W-1:0]    ms_result,
    input  wire                           ms_ex,
    input  wire lsu_pkg::exc_code_e       ms_exc_code,
    // register file read ports
    input  wire  [lsu_pkg::REG_AW-1:0]    rf_raddr1,
    input  wire  [lsu_pkg::REG_AW-1:0]    rf_raddr2,
    output logic [lsu_pkg::DATA_W-1:0]    rf_rdata1,
    output logic [lsu_pkg::DATA_W-1:0]    rf_rdata2,
    // retire port
    output logic                          ret_valid,
    input  wire                           ret_ready,
    output lsu_pkg::mem_op_e              ret_op,
    output logic [lsu_pkg::REG_AW-1:0]    ret_dest,
    output logic                          ret_we,
    output logic [lsu_pkg::DATA_W-1:0]    ret_data,
    output logic                          ret_ex,
    output lsu_pkg::exc_code_e            ret_exc_code
);
    import lsu_pkg::*;

    logic              ws_valid;
    logic              rf_we;
    logic              pend_hit1;
    logic              pend_hit2;
    logic [DATA_W-1:0] rf [2**REG_AW];

    assign ws_allowin = !ws_valid || ret_ready;
    assign ret_valid  = ws_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid && ws_allowin) begin
            ret_op       <= ms_op;
            ret_dest     <= ms_dest;
            ret_we       <= ms_gr_we;  // already low for stores, faults and r0
            ret_data     <= ms_result;
            ret_ex       <= ms_ex;
            ret_exc_code <= ms_exc_code;
        end
    end

    // commit on the retire handshake
    assign rf_we = ws_valid && ret_ready && ret_we;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**REG_AW; i++) begin
                rf[i] <= '0;
            end
        end else if (rf_we) begin
            rf[ret_dest] <= ret_data;
        end
    end

    // a held write shows on the read ports before it commits
    assign pend_hit1 = ws_valid && ret_we && ret_dest == rf_raddr1;
    assign pend_hit2 = ws_valid && ret_we && ret_dest == rf_raddr2;

    assign rf_rdata1 = (rf_raddr1 == '0) ? '0 : pend_hit1 ? ret_data : rf[rf_raddr1];
    assign rf_rdata2 = (rf_raddr2 == '0) ? '0 : pend_hit2 ? ret_data : rf[rf_raddr2];

endmodule

`default_nettype wire

// ==== rtl/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  wire                          clk,
    input  wire                          reset,
    // issue port
    input  wire                          in_valid,
    output wire                          in_allowin,
    input  wire lsu_pkg::mem_op_e        in_op,
    input  wire [lsu_pkg::REG_AW-1:0]    in_rs,
    input  wire [lsu_pkg::REG_AW-1:0]    in_rt,
    input  wire [lsu_pkg::REG_AW-1:0]    in_dest,
    input  wire [15:0]                   in_imm,
    // retire port
    output wire                          ret_valid,
    input  wire                          ret_ready,
    output wire lsu_pkg::mem_op_e        ret_op,
    output wire [lsu_pkg::REG_AW-1:0]    ret_dest,
    output wire                          ret_we,
    output wire [lsu_pkg::DATA_W-1:0]    ret_data,
    output wire                          ret_ex,
    output wire lsu_pkg::exc_code_e      ret_exc_code
);
    import lsu_pkg::*;

    // register file reads and mem bypass
    wire [REG_AW-1:0] rf_raddr1;
    wire [REG_AW-1:0] rf_raddr2;
    wire [DATA_W-1:0] rf_rdata1;
    wire [DATA_W-1:0] rf_rdata2;
    wire              ms_fwd_valid;
    wire [REG_AW-1:0] ms_fwd_dest;
    wire [DATA_W-1:0] ms_fwd_data;

    // exe to mem
    wire              ms_allowin;
    wire              es_to_ms_valid;
    wire mem_op_e     es_op;
    wire [REG_AW-1:0] es_dest;
    wire              es_gr_we;
    wire [DATA_W-1:0] es_result;
    wire [DATA_W-1:0] es_rt_value;
    wire              es_ex;
    wire exc_code_e   es_exc_code;

    // data ram
    wire              ram_en;
    wire [3:0]        ram_wen;
    wire [RAM_AW-1:0] ram_addr;
    wire [DATA_W-1:0] ram_wdata;
    wire [DATA_W-1:0] ram_rdata;

    // mem to wb
    wire              ws_allowin;
    wire              ms_to_ws_valid;
    wire mem_op_e     ms_op;
    wire [REG_AW-1:0] ms_dest;
    wire              ms_gr_we;
    wire [DATA_W-1:0] ms_result;
    wire              ms_ex;
    wire exc_code_e   ms_exc_code;

    // port names match the nets above one for one
    exe_stage u_exe_stage (.*);

    data_ram u_data_ram (.*);

    mem_stage u_mem_stage (.*);

    wb_stage u_wb_stage (.*);

endmodule

`default_nettype wire

// ==== verif/tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;  // released just after an edge
    end

endmodule

`default_nettype wire

// ==== verif/tb_vectors.svh ====
// one row per instruction, expected values worked out by hand
// base register r6 holds 0x100 and r4 holds 0xffff8765 once the addi rows have run
typedef struct packed {
    mem_op_e          op;
    logic [4:0]       rs;
    logic [4:0]       rt;
    logic [4:0]       dest;
    logic [15:0]      imm;
    logic             we;    // expected ret_we
    logic [31:0]      data;  // expected ret_data
    logic             ex;
    exc_code_e        code;
} vec_t;

vec_t  rows[$];
string row_names[$];

task automatic add_row(input string name, input mem_op_e op, input int rs, input int rt,
                       input int dest, input logic [15:0] imm, input logic we,
                       input logic [31:0] data, input logic ex, input exc_code_e code);
    vec_t v;
    v.op   = op;
    v.rs   = rs[4:0];
    v.rt   = rt[4:0];
    v.dest = dest[4:0];
    v.imm  = imm;
    v.we   = we;
    v.data = data;
    v.ex   = ex;
    v.code = code;
    rows.push_back(v);
    row_names.push_back(name);
endtask

task automatic fill_table();
    // reset contents, addi and forwarding
    add_row("reset_lw",    OP_LW,   0, 0, 1,  16'h0040, 1'b1, 32'h0000_0000, 1'b0, EXC_NONE);
    add_row("addi_r1",     OP_ADDI, 0, 0, 1,  16'h1234, 1'b1, 32'h0000_1234, 1'b0, EXC_NONE);
    add_row("addi_fwd_ms", OP_ADDI, 1, 0, 2,  16'h0100, 1'b1, 32'h0000_1334, 1'b0, EXC_NONE);
    add_row("addi_fwd_ws", OP_ADDI, 1, 0, 3,  16'hffff, 1'b1, 32'h0000_1233, 1'b0, EXC_NONE);
    add_row("addi_r4",     OP_ADDI, 0, 0, 4,  16'h8765, 1'b1, 32'hffff_8765, 1'b0, EXC_NONE);
    add_row("addi_r6",     OP_ADDI, 0, 0, 6,  16'h0100, 1'b1, 32'h0000_0100, 1'b0, EXC_NONE);
    add_row("addi_r0",     OP_ADDI, 1, 0, 0,  16'h0005, 1'b0, 32'h0000_1239, 1'b0, EXC_NONE);
    // word at 0x100 then narrow loads from it
    add_row("sw_0",        OP_SW,   6, 4, 0,  16'h0000, 1'b0, 32'h0000_0100, 1'b0, EXC_NONE);
    add_row("lw_0",        OP_LW,   6, 0, 7,  16'h0000, 1'b1, 32'hffff_8765, 1'b0, EXC_NONE);
    add_row("lb_1",        OP_LB,   6, 0, 8,  16'h0001, 1'b1, 32'hffff_ff87, 1'b0, EXC_NONE);
    add_row("lbu_1",       OP_LBU,  6, 0, 9,  16'h0001, 1'b1, 32'h0000_0087, 1'b0, EXC_NONE);
    add_row("lb_0",        OP_LB,   6, 0, 8,  16'h0000, 1'b1, 32'h0000_0065, 1'b0, EXC_NONE);
    add_row("lh_0",        OP_LH,   6, 0, 10, 16'h0000, 1'b1, 32'hffff_8765, 1'b0, EXC_NONE);
    add_row("lhu_0",       OP_LHU,  6, 0, 10, 16'h0000, 1'b1, 32'h0000_8765, 1'b0, EXC_NONE);
    add_row("lhu_2",       OP_LHU,  6, 0, 10, 16'h0002, 1'b1, 32'h0000_ffff, 1'b0, EXC_NONE);
    // word 0x104 built from byte and half stores
    add_row("sb_5",        OP_SB,   6, 2, 0,  16'h0005, 1'b0, 32'h0000_0105, 1'b0, EXC_NONE);
    add_row("sh_6",        OP_SH,   6, 1, 0,  16'h0006, 1'b0, 32'h0000_0106, 1'b0, EXC_NONE);
    add_row("sb_4",        OP_SB,   6, 3, 0,  16'h0004, 1'b0, 32'h0000_0104, 1'b0, EXC_NONE);
    add_row("sb_7",        OP_SB,   6, 4, 0,  16'h0007, 1'b0, 32'h0000_0107, 1'b0, EXC_NONE);
    add_row("lw_4",        OP_LW,   6, 0, 11, 16'h0004, 1'b1, 32'h6534_3433, 1'b0, EXC_NONE);
    add_row("lh_6",        OP_LH,   6, 0, 12, 16'h0006, 1'b1, 32'h0000_6534, 1'b0, EXC_NONE);
    add_row("lb_6",        OP_LB,   6, 0, 12, 16'h0006, 1'b1, 32'h0000_0034, 1'b0, EXC_NONE);
    add_row("sh_2",        OP_SH,   6, 1, 0,  16'h0002, 1'b0, 32'h0000_0102, 1'b0, EXC_NONE);
    add_row("lw_merged",   OP_LW,   6, 0, 11, 16'h0000, 1'b1, 32'h1234_8765, 1'b0, EXC_NONE);
    // merges against 0x12348765 with rt = 0xffff8765
    add_row("lwl_0",       OP_LWL,  6, 4, 13, 16'h0000, 1'b1, 32'h65ff_8765, 1'b0, EXC_NONE);
    add_row("lwl_1",       OP_LWL,  6, 4, 13, 16'h0001, 1'b1, 32'h8765_8765, 1'b0, EXC_NONE);
    add_row("lwl_2",       OP_LWL,  6, 4, 13, 16'h0002, 1'b1, 32'h3487_6565, 1'b0, EXC_NONE);
    add_row("lwl_3",       OP_LWL,  6, 4, 13, 16'h0003, 1'b1, 32'h1234_8765, 1'b0, EXC_NONE);
    add_row("lwr_0",       OP_LWR,  6, 4, 13, 16'h0000, 1'b1, 32'h1234_8765, 1'b0, EXC_NONE);
    add_row("lwr_1",       OP_LWR,  6, 4, 13, 16'h0001, 1'b1, 32'hff12_3487, 1'b0, EXC_NONE);
    add_row("lwr_2",       OP_LWR,  6, 4, 13, 16'h0002, 1'b1, 32'hffff_1234, 1'b0, EXC_NONE);
    add_row("lwr_3",       OP_LWR,  6, 4, 13, 16'h0003, 1'b1, 32'hffff_8712, 1'b0, EXC_NONE);
    // partial stores into clean words, each read back
    add_row("swl_0",       OP_SWL,  6, 4, 0,  16'h0010, 1'b0, 32'h0000_0110, 1'b0, EXC_NONE);
    add_row("swl_0_rd",    OP_LW,   6, 0, 14, 16'h0010, 1'b1, 32'h0000_00ff, 1'b0, EXC_NONE);
    add_row("swl_1",       OP_SWL,  6, 4, 0,  16'h0015, 1'b0, 32'h0000_0115, 1'b0, EXC_NONE);
    add_row("swl_1_rd",    OP_LW,   6, 0, 14, 16'h0014, 1'b1, 32'h0000_ffff, 1'b0, EXC_NONE);
    add_row("swl_2",       OP_SWL,  6, 4, 0,  16'h001a, 1'b0, 32'h0000_011a, 1'b0, EXC_NONE);
    add_row("swl_2_rd",    OP_LW,   6, 0, 14, 16'h0018, 1'b1, 32'h00ff_ff87, 1'b0, EXC_NONE);
    add_row("swl_3",       OP_SWL,  6, 4, 0,  16'h001f, 1'b0, 32'h0000_011f, 1'b0, EXC_NONE);
    add_row("swl_3_rd",    OP_LW,   6, 0, 14, 16'h001c, 1'b1, 32'hffff_8765, 1'b0, EXC_NONE);
    add_row("swr_0",       OP_SWR,  6, 4, 0,  16'h0020, 1'b0, 32'h0000_0120, 1'b0, EXC_NONE);
    add_row("swr_0_rd",    OP_LW,   6, 0, 14, 16'h0020, 1'b1, 32'hffff_8765, 1'b0, EXC_NONE);
    add_row("swr_1",       OP_SWR,  6, 4, 0,  16'h0025, 1'b0, 32'h0000_0125, 1'b0, EXC_NONE);
    add_row("swr_1_rd",    OP_LW,   6, 0, 14, 16'h0024, 1'b1, 32'hff87_6500, 1'b0, EXC_NONE);
    add_row("swr_2",       OP_SWR,  6, 4, 0,  16'h002a, 1'b0, 32'h0000_012a, 1'b0, EXC_NONE);
    add_row("swr_2_rd",    OP_LW,   6, 0, 14, 16'h0028, 1'b1, 32'h8765_0000, 1'b0, EXC_NONE);
    add_row("swr_3",       OP_SWR,  6, 4, 0,  16'h002f, 1'b0, 32'h0000_012f, 1'b0, EXC_NONE);
    add_row("swr_3_rd",    OP_LW,   6, 0, 14, 16'h002c, 1'b1, 32'h6500_0000, 1'b0, EXC_NONE);
    // address errors leave registers and memory alone
    add_row("lh_misalign", OP_LH,   6, 0, 7,  16'h0001, 1'b0, 32'h0000_0101, 1'b1, EXC_ADEL);
    add_row("lw_misalign", OP_LW,   6, 0, 7,  16'h0002, 1'b0, 32'h0000_0102, 1'b1, EXC_ADEL);
    add_row("r7_kept",     OP_ADDI, 7, 0, 15, 16'h0000, 1'b1, 32'hffff_8765, 1'b0, EXC_NONE);
    add_row("sw_misalign", OP_SW,   6, 1, 0,  16'h0003, 1'b0, 32'h0000_0103, 1'b1, EXC_ADES);
    add_row("sh_misalign", OP_SH,   6, 1, 0,  16'h0005, 1'b0, 32'h0000_0105, 1'b1, EXC_ADES);
    add_row("lw_0_kept",   OP_LW,   6, 0, 11, 16'h0000, 1'b1, 32'h1234_8765, 1'b0, EXC_NONE);
    add_row("lw_4_kept",   OP_LW,   6, 0, 11, 16'h0004, 1'b1, 32'h6534_3433, 1'b0, EXC_NONE);
endtask

// ==== verif/tb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         in_allowin,
    input  wire                         ret_valid,
    input  wire                         ret_ready,
    input  wire lsu_pkg::mem_op_e       ret_op,
    input  wire [lsu_pkg::REG_AW-1:0]   ret_dest,
    input  wire                         ret_we,
    input  wire [lsu_pkg::DATA_W-1:0]   ret_data,
    input  wire                         ret_ex,
    input  wire lsu_pkg::exc_code_e     ret_exc_code,
    input  int                          total,
    output int                          checked_count,
    output int                          error_count
);
    import lsu_pkg::*;
    `include "tb_vectors.svh"

    int   retired = 0;
    int   errors  = 0;
    int   idx;
    logic reset_seen = 1'b0;

    assign checked_count = retired;
    assign error_count   = errors;

    initial fill_table();

    task automatic compare_field(input string name, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s %s expected %h actual %h", name, field, expected, actual);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        // pipeline must be empty on the first edge out of reset
        if (!reset && !reset_seen) begin
            reset_seen = 1'b1;
            if (ret_valid !== 1'b0) begin
                $display("ret_valid is not low after reset");
                errors++;
            end
            if (in_allowin !== 1'b1) begin
                $display("in_allowin is not high after reset");
                errors++;
            end
        end
        if (!reset && ret_valid && ret_ready) begin
            if (retired >= total) begin
                $display("unexpected extra retirement with op %0d and data %h", ret_op, ret_data);
                errors++;
            end else begin
                idx = retired % rows.size();  // table applied once per pass
                compare_field(row_names[idx], "ret_op", 32'(rows[idx].op), 32'(ret_op));
                compare_field(row_names[idx], "ret_dest", 32'(rows[idx].dest), 32'(ret_dest));
                compare_field(row_names[idx], "ret_we", 32'(rows[idx].we), 32'(ret_we));
                compare_field(row_names[idx], "ret_data", rows[idx].data, ret_data);
                compare_field(row_names[idx], "ret_ex", 32'(rows[idx].ex), 32'(ret_ex));
                compare_field(row_names[idx], "ret_exc_code", 32'(rows[idx].code),
                              32'(ret_exc_code));
            end
            retired++;
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;
    import lsu_pkg::*;
    `include "tb_vectors.svh"

    localparam int PASSES        = 2;    // second pass runs with random ret_ready
    localparam int ISSUE_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 4000;

    logic              clk;
    logic              reset;
    logic              in_valid;
    logic              in_allowin;
    mem_op_e           in_op;
    logic [REG_AW-1:0] in_rs;
    logic [REG_AW-1:0] in_rt;
    logic [REG_AW-1:0] in_dest;
    logic [15:0]       in_imm;
    logic              ret_valid;
    logic              ret_ready;
    mem_op_e           ret_op;
    logic [REG_AW-1:0] ret_dest;
    logic              ret_we;
    logic [DATA_W-1:0] ret_data;
    logic              ret_ex;
    exc_code_e         ret_exc_code;

    int          total_rows;
    int          checked;
    int          value_errors;
    int          timeouts;
    logic        stall_enable;
    logic [31:0] lfsr_state;
    logic        ready_bit_a;

    tb_clkgen u_clkgen (.clk(clk), .reset(reset));

    lsu_top DUT (.*);

    tb_checker u_checker (
        .clk, .reset, .in_allowin, .ret_valid, .ret_ready, .ret_op, .ret_dest,
        .ret_we, .ret_data, .ret_ex, .ret_exc_code,
        .total         (total_rows),
        .checked_count (checked),
        .error_count   (value_errors)
    );

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // ready 3 cycles in 4 on average
    always @(posedge clk) begin
        #1;
        if (stall_enable) begin
            lfsr_state  = lfsr_next(lfsr_state);
            ready_bit_a = lfsr_state[0];
            lfsr_state  = lfsr_next(lfsr_state);
            ret_ready   = ready_bit_a | lfsr_state[0];
        end else begin
            ret_ready = 1'b1;
        end
    end

    task automatic issue_row(input int idx);
        int wait_cycles;
        wait_cycles = 0;
        in_valid = 1'b1;
        in_op    = rows[idx].op;
        in_rs    = rows[idx].rs;
        in_rt    = rows[idx].rt;
        in_dest  = rows[idx].dest;
        in_imm   = rows[idx].imm;
        @(negedge clk);
        while (!in_allowin && wait_cycles < ISSUE_TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (!in_allowin) begin
            $display("in_allowin stayed low too long for row %0d (%s)", idx, row_names[idx]);
            timeouts++;
        end
        @(posedge clk);  // accepted here
        #1;
        in_valid = 1'b0;
    endtask

    initial begin
        int wait_cycles;
        fill_table();
        in_valid     = 1'b0;
        in_op        = OP_ADDI;
        in_rs        = '0;
        in_rt        = '0;
        in_dest      = '0;
        in_imm       = '0;
        ret_ready    = 1'b1;
        stall_enable = 1'b0;
        lfsr_state   = 32'hb699_ae61;
        timeouts     = 0;
        total_rows   = rows.size() * PASSES;

        wait_cycles = 0;
        @(posedge clk);  // reset is surely high by the first edge
        while (reset && wait_cycles < 100) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (reset) begin
            $display("reset was never released");
            timeouts++;
        end
        @(posedge clk);
        #1;

        for (int pass = 0; pass < PASSES; pass++) begin
            stall_enable = (pass == 1);
            for (int i = 0; i < rows.size(); i++) begin
                issue_row(i);
            end
        end

        wait_cycles = 0;
        while (checked < total_rows && wait_cycles < DRAIN_TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (checked < total_rows) begin
            $display("missing retirement, only %0d of %0d rows retired", checked, total_rows);
            timeouts++;
        end
        repeat (20) @(negedge clk);  // leaves room for a stray extra retirement

        $display("errors: %0d value, %0d timeout; retired %0d of %0d",
                 value_errors, timeouts, checked, total_rows);
        if (value_errors == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+verif
rtl/lsu_pkg.sv
rtl/data_ram.sv
rtl/load_align.sv
rtl/exe_stage.sv
rtl/mem_stage.sv
rtl/wb_stage.sv
rtl/lsu_top.sv
verif/tb_clkgen.sv
verif/tb_checker.sv
verif/tb_lsu.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := tb_lsu
FILELIST := vlog.f
OBJ_DIR  := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run $(TOP)"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
